/* include/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// register file addressing
`define REG_ADDR_W     5
// rs1, rs2 and rs3
`define NUM_SRC        3

// instruction word and its source fields
`define INSTR_W        32
`define RS1_LSB        15
`define RS2_LSB        20
`define RS3_LSB        25

// testbench timing in ns
`define CLK_PERIOD     100
`define STIM_DELAY     10
// reset length and run limit in cycles
`define RST_CYCLES     16
`define TIMEOUT_MARGIN 20

`endif

/* project.f */
+incdir+include
rtl/fwd_pkg.sv
rtl/flow_pkg.sv
rtl/operand_src_decode.sv
rtl/operand_fwd_slice.sv
rtl/hazard_merge.sv
rtl/ctrl_fsm.sv
rtl/id_ctrl.sv
tb/id_ctrl_properties.sv
tb/id_ctrl_tb.sv

/* rtl/ctrl_fsm.sv */
module ctrl_fsm
  import flow_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       pipe_flush_i,
  input  jump_kind_t jump_in_dec_i,
  input  jump_kind_t jump_in_ex_i,
  input  logic       branch_decision_i,
  input  logic       jr_stall_i,
  // stage completion
  input  logic       id_valid_i,
  input  logic       ex_valid_i,
  input  logic       wb_valid_i,
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_sel_t    pc_mux_sel_o,
  output logic       core_busy_o,
  output logic       is_decoding_o,
  output logic       halt_if_o,
  output logic       halt_id_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        branch_taken_ex;
  logic        uncond_jump_dec;

  // conditional branch in EX resolved as taken
  assign branch_taken_ex = (jump_in_ex_i == COND) && branch_decision_i;
  // target of jal and jalr is known in decode
  assign uncond_jump_dec = (jump_in_dec_i == JAL) || (jump_in_dec_i == JALR);

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////
  always_comb
  begin
    state_d       = state_q;
    instr_req_o   = 1'b1;
    core_busy_o   = 1'b1;
    pc_set_o      = 1'b0;
    pc_mux_sel_o  = PC_BOOT;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    unique case (state_q)
      // idle after reset until fetch is enabled
      RESET:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load boot address into the fetch PC
      BOOT_SET:
      begin
        pc_mux_sel_o = PC_BOOT;
        pc_set_o     = 1'b1;
        state_d      = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        if (id_valid_i)
          state_d = DECODE;
      end

      DECODE:
      begin
        // decode only when no taken branch squashes this slot
        if (instr_valid_i && !branch_taken_ex)
        begin
          is_decoding_o = 1'b1;
          // redirect right away, held off by the jr stall
          if (uncond_jump_dec)
          begin
            pc_mux_sel_o = PC_JUMP;
            if (!jr_stall_i)
              pc_set_o = 1'b1;
          end
          // wfi style flush
          if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end
        // taken branch overrides the instruction in ID
        if (branch_taken_ex)
        begin
          pc_mux_sel_o = PC_BRANCH;
          pc_set_o     = 1'b1;
        end
      end

      // drain EX
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // drain WB, then sleep or resume
      FLUSH_WB:
      begin
        if (!fetch_enable_i)
        begin
          halt_if_o = 1'b1;
          if (wb_valid_i)
            state_d = SLEEP;
        end
        else
        begin
          if (id_valid_i)
            state_d = DECODE;
        end
      end

      // core stopped, no fetching
      SLEEP:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = FIRST_FETCH;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= RESET;
    else
      state_q <= state_d;
  end

endmodule

/* rtl/flow_pkg.sv */
package flow_pkg;

  ////////////////////////////////////////
  // control flow types
  ////////////////////////////////////////

  // main controller states
  typedef enum logic [2:0]
  {
    RESET, BOOT_SET, FIRST_FETCH, DECODE,
    FLUSH_EX, FLUSH_WB, SLEEP
  } ctrl_state_t;

  // next PC source for the fetch stage
  typedef enum logic [1:0]
  {
    PC_BOOT   = 2'b00,
    PC_JUMP   = 2'b01,
    PC_BRANCH = 2'b10
  } pc_sel_t;

  // kind of jump carried by an instruction
  typedef enum logic [1:0] {NONE, JAL, JALR, COND} jump_kind_t;

endpackage

/* rtl/fwd_pkg.sv */
`include "ctrl_params.svh"

package fwd_pkg;

  ////////////////////////////////////////
  // operand side types
  ////////////////////////////////////////

  // index into the register file
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // source of one ID stage operand
  // regfile read, ALU result from EX, or writeback data
  typedef enum logic [1:0]
  {
    REGFILE = 2'b00,
    FW_EX   = 2'b01,
    FW_WB   = 2'b10
  } fwd_sel_t;

endpackage

/* rtl/hazard_merge.sv */
`include "ctrl_params.svh"

module hazard_merge
  import flow_pkg::*;
(
  // per operand hits from the forwarding slices
  input  logic [`NUM_SRC-1:0] hit_ex_i,
  input  logic [`NUM_SRC-1:0] hit_wb_i,
  input  logic [`NUM_SRC-1:0] hit_alu_i,
  // load or store in EX
  input  logic                data_req_ex_i,
  input  jump_kind_t          jump_in_dec_i,
  input  logic                illegal_insn_i,
  input  logic                is_decoding_i,
  output logic                load_stall_o,
  output logic                jr_stall_o,
  output logic                deassert_we_o
);

  logic rs1_in_flight;
  logic is_jalr;

  ////////////////////////////////////////
  // stall detection
  ////////////////////////////////////////

  // load result not yet available for a source in ID
  assign load_stall_o = data_req_ex_i & (|hit_ex_i);

  // jump target register still being written by any stage
  assign rs1_in_flight = hit_ex_i[0] | hit_wb_i[0] | hit_alu_i[0];
  assign is_jalr       = (jump_in_dec_i == JALR);
  assign jr_stall_o    = is_jalr & rs1_in_flight;

  ////////////////////////////////////////
  // write enable suppression
  ////////////////////////////////////////

  // the instruction in ID must not write back when
  // it stalls, is illegal, or is not being decoded at all
  assign deassert_we_o = load_stall_o | jr_stall_o | illegal_insn_i | ~is_decoding_i;

endmodule

/* rtl/id_ctrl.sv */
`include "ctrl_params.svh"

module id_ctrl
  import fwd_pkg::*, flow_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable_i,
  input  logic [`INSTR_W-1:0] instr_rdata_i,
  input  logic                instr_valid_i,
  input  logic                rega_used_i,
  input  logic                regb_used_i,
  input  logic                regc_used_i,
  input  logic                illegal_insn_i,
  input  logic                pipe_flush_i,
  input  logic                data_req_ex_i,
  input  jump_kind_t          jump_in_dec_i,
  input  jump_kind_t          jump_in_ex_i,
  input  logic                branch_decision_i,
  // in-flight register writes
  input  reg_addr_t           waddr_ex_i,
  input  logic                we_ex_i,
  input  reg_addr_t           waddr_wb_i,
  input  logic                we_wb_i,
  input  reg_addr_t           alu_waddr_i,
  input  logic                alu_we_i,
  input  logic                id_valid_i,
  input  logic                ex_valid_i,
  input  logic                wb_valid_i,
  output fwd_sel_t            operand_a_fw_sel_o,
  output fwd_sel_t            operand_b_fw_sel_o,
  output fwd_sel_t            operand_c_fw_sel_o,
  output logic                load_stall_o,
  output logic                jr_stall_o,
  output logic                deassert_we_o,
  output logic                instr_req_o,
  output logic                pc_set_o,
  output pc_sel_t             pc_mux_sel_o,
  output logic                core_busy_o,
  output logic                is_decoding_o,
  output logic                halt_if_o,
  output logic                halt_id_o
);

  reg_addr_t           src_addr [`NUM_SRC];
  logic [`NUM_SRC-1:0] src_used;
  logic [`NUM_SRC-1:0] src_fwd_ok;
  logic [`NUM_SRC-1:0] hit_ex;
  logic [`NUM_SRC-1:0] hit_wb;
  logic [`NUM_SRC-1:0] hit_alu;
  fwd_sel_t            fwd_sel [`NUM_SRC];

  operand_src_decode src_decode_i (
    .instr_rdata_i, .rega_used_i, .regb_used_i, .regc_used_i,
    .src_addr_o   (src_addr),
    .src_used_o   (src_used),
    .src_fwd_ok_o (src_fwd_ok)
  );

  // one forwarding slice per source operand
  for (genvar k = 0; k < `NUM_SRC; k++)
  begin : gen_fwd
    operand_fwd_slice fwd_slice_i (
      .src_addr_i (src_addr[k]), .src_used_i (src_used[k]), .src_fwd_ok_i (src_fwd_ok[k]),
      .waddr_ex_i, .we_ex_i, .waddr_wb_i, .we_wb_i, .alu_waddr_i, .alu_we_i,
      .fwd_sel_o  (fwd_sel[k]),
      .hit_ex_o   (hit_ex[k]), .hit_wb_o (hit_wb[k]), .hit_alu_o (hit_alu[k])
    );
  end

  // operand mux selects in a, b, c order
  assign operand_a_fw_sel_o = fwd_sel[0];
  assign operand_b_fw_sel_o = fwd_sel[1];
  assign operand_c_fw_sel_o = fwd_sel[2];

  hazard_merge hazard_merge_i (
    .hit_ex_i (hit_ex), .hit_wb_i (hit_wb), .hit_alu_i (hit_alu),
    .data_req_ex_i, .jump_in_dec_i, .illegal_insn_i,
    .is_decoding_i (is_decoding_o),
    .load_stall_o, .jr_stall_o, .deassert_we_o
  );

  // jr stall feeds back into the FSM for redirect hold-off
  ctrl_fsm ctrl_fsm_i (
    .clk, .rst_n, .fetch_enable_i, .instr_valid_i, .pipe_flush_i,
    .jump_in_dec_i, .jump_in_ex_i, .branch_decision_i,
    .jr_stall_i (jr_stall_o),
    .id_valid_i, .ex_valid_i, .wb_valid_i,
    .instr_req_o, .pc_set_o, .pc_mux_sel_o, .core_busy_o,
    .is_decoding_o, .halt_if_o, .halt_id_o
  );

endmodule

/* rtl/operand_fwd_slice.sv */
module operand_fwd_slice
  import fwd_pkg::*;
(
  // operand under decode
  input  reg_addr_t src_addr_i,
  input  logic      src_used_i,
  input  logic      src_fwd_ok_i,
  // EX stage write port
  input  reg_addr_t waddr_ex_i,
  input  logic      we_ex_i,
  // WB stage write port
  input  reg_addr_t waddr_wb_i,
  input  logic      we_wb_i,
  // ALU result forwarding port
  input  reg_addr_t alu_waddr_i,
  input  logic      alu_we_i,
  output fwd_sel_t  fwd_sel_o,
  output logic      hit_ex_o,
  output logic      hit_wb_o,
  output logic      hit_alu_o
);

  logic match_ex;
  logic match_wb;
  logic match_alu;

  // raw address compares
  assign match_ex  = (waddr_ex_i  == src_addr_i);
  assign match_wb  = (waddr_wb_i  == src_addr_i);
  assign match_alu = (alu_waddr_i == src_addr_i);

  // a hit needs a live write and an operand that is read
  assign hit_ex_o  = we_ex_i  & match_ex  & src_used_i;
  assign hit_wb_o  = we_wb_i  & match_wb  & src_used_i;
  assign hit_alu_o = alu_we_i & match_alu & src_used_i;

  // forwarding mux select
  always_comb
  begin
    fwd_sel_o = REGFILE;
    if (src_fwd_ok_i)
    begin
      // youngest result wins
      if (hit_alu_o)
        fwd_sel_o = FW_EX;
      else if (hit_wb_o)
        fwd_sel_o = FW_WB;
    end
  end

endmodule

/* rtl/operand_src_decode.sv */
`include "ctrl_params.svh"

module operand_src_decode
  import fwd_pkg::*;
(
  input  logic [`INSTR_W-1:0] instr_rdata_i,
  input  logic                rega_used_i,
  input  logic                regb_used_i,
  input  logic                regc_used_i,
  output reg_addr_t           src_addr_o [`NUM_SRC],
  output logic [`NUM_SRC-1:0] src_used_o,
  output logic [`NUM_SRC-1:0] src_fwd_ok_o
);

  // field positions in the instruction, rs1 first
  localparam int unsigned SRC_LSB [`NUM_SRC] = '{`RS1_LSB, `RS2_LSB, `RS3_LSB};
  // rs1 and rs2 may name x0, which reads as zero
  localparam int unsigned NUM_X0_SRC = 2;

  // used flags in operand order
  assign src_used_o = {regc_used_i, regb_used_i, rega_used_i};

  always_comb
  begin
    for (int k = 0; k < `NUM_SRC; k++)
    begin
      // slice the source field
      src_addr_o[k]   = instr_rdata_i[SRC_LSB[k] +: `REG_ADDR_W];
      // a used operand may take forwarded data
      src_fwd_ok_o[k] = src_used_o[k];
      // x0 is never forwarded
      if ((k < NUM_X0_SRC) && (src_addr_o[k] == '0))
        src_fwd_ok_o[k] = 1'b0;
    end
  end

endmodule

/* tb/id_ctrl_properties.sv */
module ctrl_fsm_properties
  import flow_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        pc_set_o,
  input pc_sel_t     pc_mux_sel_o,
  input logic        branch_decision_i,
  input logic        halt_if_o,
  input ctrl_state_t state_q
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // redirect rules
  ////////////////////////////////////////

  // a branch redirect needs a resolved decision
  branch_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_o && (pc_mux_sel_o == PC_BRANCH)) |-> !$isunknown(branch_decision_i))
    else $error("branch redirect with unknown branch decision");

  // no PC update while idle
  idle_no_pc_set_a: assert property (@(posedge clk) disable iff (!rst_n)
    ((state_q == RESET) || (state_q == SLEEP)) |-> !pc_set_o)
    else $error("pc_set raised in RESET or SLEEP");

  // fetch stays halted while EX drains
  flush_halt_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == FLUSH_EX) |-> halt_if_o)
    else $error("halt_if low during FLUSH_EX");

endmodule

/* tb/id_ctrl_tb.sv */
`include "ctrl_params.svh"

module id_ctrl_tb
  import fwd_pkg::*, flow_pkg::*;
  ;

  timeunit 1ns;
  timeprecision 100ps;

  // fsm vector is {req, pc_set, pc_sel[1:0], busy, decoding, halt_if, halt_id}
  localparam logic [7:0] ALL      = 8'hff;
  localparam logic [7:0] NO_SEL   = 8'b1_1_00_1_1_1_1;
  localparam logic [7:0] DEC_IDLE = 8'b1_0_00_1_1_0_0;
  localparam int         RAND_ROWS = 12;

  // one table row of DUT inputs
  // each writer port is packed as {we, addr}
  typedef struct packed {
    logic       fetch_en;
    logic       instr_valid;
    logic [2:0] vld;
    jump_kind_t jdec;
    jump_kind_t jex;
    logic       bdec;
    logic       flush;
    logic [2:0] used;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rs3;
    logic [5:0] ex_wr;
    logic [5:0] wb_wr;
    logic [5:0] alu_wr;
    logic       dreq;
    logic       illegal;
  } stim_t;

  logic clk, rst_n, fetch_enable_i, instr_valid_i, illegal_insn_i, pipe_flush_i;
  logic [`INSTR_W-1:0] instr_rdata_i;
  logic rega_used_i, regb_used_i, regc_used_i, data_req_ex_i, branch_decision_i;
  jump_kind_t jump_in_dec_i, jump_in_ex_i;
  reg_addr_t waddr_ex_i, waddr_wb_i, alu_waddr_i;
  logic we_ex_i, we_wb_i, alu_we_i, id_valid_i, ex_valid_i, wb_valid_i;
  fwd_sel_t operand_a_fw_sel_o, operand_b_fw_sel_o, operand_c_fw_sel_o;
  logic load_stall_o, jr_stall_o, deassert_we_o, instr_req_o, pc_set_o;
  pc_sel_t pc_mux_sel_o;
  logic core_busy_o, is_decoding_o, halt_if_o, halt_id_o;

  stim_t       stim_q [$];
  logic [7:0]  fsm_exp_q [$];
  logic [7:0]  fsm_mask_q [$];
  logic [31:0] rnd = 32'hbaff_ab4d;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  id_ctrl id_ctrl_i (.*);

  bind ctrl_fsm ctrl_fsm_properties props_i (.*);

  initial clk = 1'b0;
  always #(`CLK_PERIOD / 2) clk = ~clk;

  // watchdog on the whole run
  always @(posedge clk)
  begin
    cycles++;
    if ((cycle_limit > 0) && (cycles >= cycle_limit))
    begin
      $display("timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // control part of a row with the operand fields zero
  function automatic stim_t ctl(input logic fe, input logic iv, input logic [2:0] vld,
                                input jump_kind_t jd, input jump_kind_t je,
                                input logic bd, input logic fl);
    stim_t s;
    s = '0;
    s.fetch_en    = fe;
    s.instr_valid = iv;
    s.vld         = vld;
    s.jdec        = jd;
    s.jex         = je;
    s.bdec        = bd;
    s.flush       = fl;
    return s;
  endfunction

  function automatic stim_t ops(input stim_t s, input logic [2:0] used,
                                input logic [4:0] r1, input logic [4:0] r2, input logic [4:0] r3,
                                input logic [5:0] ex, input logic [5:0] wb,
                                input logic [5:0] alu, input logic dreq);
    s.used   = used;
    s.rs1    = r1;
    s.rs2    = r2;
    s.rs3    = r3;
    s.ex_wr  = ex;
    s.wb_wr  = wb;
    s.alu_wr = alu;
    s.dreq   = dreq;
    return s;
  endfunction

  // expected {sel_a, sel_b, sel_c, load_stall, jr_stall, deassert_we}
  function automatic logic [8:0] operand_model(input stim_t s, input logic decoding);
    logic [4:0] addr [3];
    logic [1:0] sel [3];
    logic       hx, hw, ha, allow, load, rs1_hit, jr;
    load    = 1'b0;
    rs1_hit = 1'b0;
    addr    = '{s.rs1, s.rs2, s.rs3};
    for (int k = 0; k < 3; k++)
    begin
      hx = s.used[k] && s.ex_wr[5] && (s.ex_wr[4:0] == addr[k]);
      hw = s.used[k] && s.wb_wr[5] && (s.wb_wr[4:0] == addr[k]);
      ha = s.used[k] && s.alu_wr[5] && (s.alu_wr[4:0] == addr[k]);
      // x0 in rs1 or rs2 is a constant zero
      allow  = s.used[k] && !((k < 2) && (addr[k] == 5'd0));
      sel[k] = REGFILE;
      if (allow && ha)
        sel[k] = FW_EX;
      else if (allow && hw)
        sel[k] = FW_WB;
      load = load | (s.dreq & hx);
      if (k == 0)
        rs1_hit = hx | hw | ha;
    end
    jr = (s.jdec == JALR) && rs1_hit;
    return {sel[0], sel[1], sel[2], load, jr, load | jr | s.illegal | ~decoding};
  endfunction

  task automatic add_row(input stim_t s, input logic [7:0] fsm_exp, input logic [7:0] mask);
    stim_q.push_back(s);
    fsm_exp_q.push_back(fsm_exp);
    fsm_mask_q.push_back(mask);
  endtask

  task automatic apply(input stim_t s);
    logic [`INSTR_W-1:0] instr;
    // register-register opcode around the source fields
    instr = 32'h0000_0033;
    instr[`RS1_LSB +: `REG_ADDR_W] = s.rs1;
    instr[`RS2_LSB +: `REG_ADDR_W] = s.rs2;
    instr[`RS3_LSB +: `REG_ADDR_W] = s.rs3;
    instr_rdata_i     = instr;
    fetch_enable_i    = s.fetch_en;
    instr_valid_i     = s.instr_valid;
    {id_valid_i, ex_valid_i, wb_valid_i} = s.vld;
    jump_in_dec_i     = s.jdec;
    jump_in_ex_i      = s.jex;
    branch_decision_i = s.bdec;
    pipe_flush_i      = s.flush;
    {regc_used_i, regb_used_i, rega_used_i} = s.used;
    {we_ex_i, waddr_ex_i}   = s.ex_wr;
    {we_wb_i, waddr_wb_i}   = s.wb_wr;
    {alu_we_i, alu_waddr_i} = s.alu_wr;
    data_req_ex_i     = s.dreq;
    illegal_insn_i    = s.illegal;
  endtask

  task automatic compare(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_row(input int i);
    logic [7:0] got_fsm;
    logic [8:0] got_ops;
    got_fsm = {instr_req_o, pc_set_o, pc_mux_sel_o, core_busy_o,
               is_decoding_o, halt_if_o, halt_id_o};
    got_ops = {operand_a_fw_sel_o, operand_b_fw_sel_o, operand_c_fw_sel_o,
               load_stall_o, jr_stall_o, deassert_we_o};
    compare(got_fsm & fsm_mask_q[i], fsm_exp_q[i] & fsm_mask_q[i],
            $sformatf("row %0d fsm outputs", i));
    compare(got_ops, operand_model(stim_q[i], fsm_exp_q[i][2]),
            $sformatf("row %0d operand outputs", i));
  endtask

  task automatic build_table();
    stim_t dec;
    stim_t jr;
    stim_t ill;
    dec = ctl(1, 1, 3'b000, NONE, NONE, 0, 0);
    jr  = ctl(1, 1, 3'b000, JALR, NONE, 0, 0);
    ////////////////////////////////////////
    // reset and boot
    add_row(ctl(0, 0, 3'b000, NONE, NONE, 0, 0), 8'b0_0_00_0_0_0_0, NO_SEL);
    add_row(ctl(1, 0, 3'b000, NONE, NONE, 0, 0), 8'b0_0_00_0_0_0_0, NO_SEL);
    add_row(ctl(1, 0, 3'b000, NONE, NONE, 0, 0), 8'b1_1_00_1_0_0_0, ALL);
    add_row(ctl(1, 0, 3'b000, NONE, NONE, 0, 0), 8'b1_0_00_1_0_0_0, NO_SEL);
    // first instruction reaches ID
    add_row(ctl(1, 0, 3'b100, NONE, NONE, 0, 0), 8'b1_0_00_1_0_0_0, NO_SEL);
    ////////////////////////////////////////
    // forwarding priority, x0 and unused operands
    add_row(ops(dec, 3'b111, 5, 6, 7, 6'h00, {1'b1, 5'd6}, {1'b1, 5'd5}, 0), DEC_IDLE, NO_SEL);
    add_row(ops(dec, 3'b111, 0, 0, 0, 6'h00, {1'b1, 5'd0}, {1'b1, 5'd0}, 0), DEC_IDLE, NO_SEL);
    add_row(ops(dec, 3'b000, 3, 3, 3, 6'h00, {1'b1, 5'd3}, {1'b1, 5'd3}, 0), DEC_IDLE, NO_SEL);
    add_row(ops(dec, 3'b111, 1, 2, 8, 6'h00, {1'b1, 5'd8}, {1'b1, 5'd8}, 0), DEC_IDLE, NO_SEL);
    // small address range so that hits are frequent
    for (int n = 0; n < RAND_ROWS; n++)
    begin
      rnd = xorshift(rnd);
      add_row(ops(dec, rnd[2:0], {3'b0, rnd[4:3]}, {3'b0, rnd[6:5]}, {3'b0, rnd[8:7]},
                  {rnd[9], 3'b0, rnd[11:10]}, {rnd[12], 3'b0, rnd[14:13]},
                  {rnd[15], 3'b0, rnd[17:16]}, rnd[18]), DEC_IDLE, NO_SEL);
    end
    ////////////////////////////////////////
    // load-use on rs2, then the same match without we_ex
    add_row(ops(dec, 3'b011, 1, 9, 4, {1'b1, 5'd9}, 6'h00, 6'h00, 1), DEC_IDLE, NO_SEL);
    add_row(ops(dec, 3'b011, 1, 9, 4, {1'b0, 5'd9}, 6'h00, 6'h00, 1), DEC_IDLE, NO_SEL);
    // jalr with rs1 in flight on each writer, then with none
    add_row(ops(jr, 3'b001, 4, 0, 0, 6'h00, 6'h00, {1'b1, 5'd4}, 0), DEC_IDLE, NO_SEL);
    add_row(ops(jr, 3'b001, 4, 0, 0, 6'h00, {1'b1, 5'd4}, 6'h00, 0), DEC_IDLE, NO_SEL);
    add_row(ops(jr, 3'b001, 4, 0, 0, {1'b1, 5'd4}, 6'h00, 6'h00, 0), DEC_IDLE, NO_SEL);
    add_row(ops(jr, 3'b001, 4, 0, 0, {1'b1, 5'd7}, {1'b1, 5'd7}, {1'b1, 5'd7}, 0),
            8'b1_1_01_1_1_0_0, ALL);
    // taken and not taken branch in EX
    add_row(ctl(1, 1, 3'b000, NONE, COND, 1, 0), 8'b1_1_10_1_0_0_0, ALL);
    add_row(ctl(1, 1, 3'b000, NONE, COND, 0, 0), DEC_IDLE, NO_SEL);
    // illegal instruction without any hazard
    ill = ops(dec, 3'b011, 1, 2, 0, 6'h00, 6'h00, 6'h00, 0);
    ill.illegal = 1'b1;
    add_row(ill, DEC_IDLE, NO_SEL);
    ////////////////////////////////////////
    // flush, drain and sleep
    add_row(ctl(0, 1, 3'b000, NONE, NONE, 0, 1), 8'b1_0_00_1_1_1_1, NO_SEL);
    add_row(ctl(0, 0, 3'b000, NONE, NONE, 0, 0), 8'b1_0_00_1_0_1_0, NO_SEL);
    add_row(ctl(0, 0, 3'b010, NONE, NONE, 0, 0), 8'b1_0_00_1_0_1_0, NO_SEL);
    add_row(ctl(0, 0, 3'b000, NONE, NONE, 0, 0), 8'b1_0_00_1_0_1_0, NO_SEL);
    add_row(ctl(0, 0, 3'b001, NONE, NONE, 0, 0), 8'b1_0_00_1_0_1_0, NO_SEL);
    add_row(ctl(0, 0, 3'b000, NONE, NONE, 0, 0), 8'b0_0_00_0_0_0_0, NO_SEL);
    // wake up into first fetch
    add_row(ctl(1, 0, 3'b000, NONE, NONE, 0, 0), 8'b0_0_00_0_0_0_0, NO_SEL);
    add_row(ctl(1, 0, 3'b000, NONE, NONE, 0, 0), 8'b1_0_00_1_0_0_0, NO_SEL);
  endtask

  initial
  begin
    rst_n = 1'b0;
    apply('0);
    build_table();
    cycle_limit = stim_q.size() + `RST_CYCLES + `TIMEOUT_MARGIN;
    repeat (`RST_CYCLES) @(posedge clk);
    #(`STIM_DELAY);
    rst_n = 1'b1;
    // drive after the edge, sample shortly before the next one
    for (int i = 0; i < stim_q.size(); i++)
    begin
      @(posedge clk);
      #(`STIM_DELAY);
      apply(stim_q[i]);
      #(`CLK_PERIOD - `STIM_DELAY - 5);
      check_row(i);
    end
    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
